// ==== design/commitPkg.sv ====
package commitPkg;

    // instruction address as seen by fetch and the reorder buffer
    typedef logic [31:0] addrT;

    // logical and physical register numbers of the rename map
    typedef logic [4:0] archRegT;
    typedef logic [5:0] physRegT;

    // exception cause, same encoding as the cause register field
    typedef logic [4:0] excCodeT;

    // what kind of control transfer a slot holds
    typedef logic [1:0] branchKindT;

    localparam branchKindT BR_NONE = 2'd0;
    localparam branchKindT BR_COND = 2'd1; // conditional branch
    localparam branchKindT BR_JUMP = 2'd2; // unconditional jump, direct or indirect

    // a not-taken branch falls through past its delay slot
    localparam addrT RETURN_OFFSET = 32'd8;

endpackage

// ==== design/branchCheck.sv ====
`timescale 1ns/1ps

module branchCheck (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   winStrobe,
    input  logic                   s0Valid,
    input  logic                   s0Busy,
    input  logic                   s0Exc,
    input  logic                   s1Bubble,
    input  logic                   s0Taken,
    input  logic                   s0PredTaken,
    input  commitPkg::branchKindT  s0BrKind,
    input  commitPkg::addrT        s0Pc,
    input  commitPkg::addrT        s0BrAddr,
    input  commitPkg::addrT        s0PredAddr,
    input  logic                   flush,
    input  logic                   waitingDelaySlot,
    output logic                   mispredict,
    output logic                   needDelaySlot,
    output commitPkg::addrT        mispredictTarget,
    output logic                   bpUpdValid,
    output logic                   bpUpdTaken,
    output commitPkg::addrT        bpUpdPc,
    output commitPkg::addrT        bpUpdTarget
);

    logic            checked;
    logic            takenMiss;
    logic            addrMiss;
    logic            missed;
    commitPkg::addrT target;

    // only the older slot can carry a branch that is resolved here
    assign checked = winStrobe && s0Valid && !s0Busy && !s0Exc && !flush && !waitingDelaySlot
                     && (s0BrKind != commitPkg::BR_NONE);

    assign takenMiss = s0Taken != s0PredTaken;
    assign addrMiss  = s0Taken && s0PredTaken && (s0BrAddr != s0PredAddr); // taken to the wrong place
    assign missed    = checked && (takenMiss || addrMiss);

    assign target = s0Taken ? s0BrAddr : s0Pc + commitPkg::RETURN_OFFSET;

    always_ff @(posedge clk) begin
        if (rst) begin
            mispredict    <= 1'b0;
            needDelaySlot <= 1'b0;
            bpUpdValid    <= 1'b0;
        end else begin
            mispredict    <= missed;
            needDelaySlot <= missed && s1Bubble; // delay slot has not reached the window yet
            bpUpdValid    <= checked;
        end
    end

    always_ff @(posedge clk) begin
        if (missed) begin
            mispredictTarget <= target;
        end
        if (checked) begin
            bpUpdPc     <= s0Pc;
            bpUpdTarget <= s0BrAddr;
            bpUpdTaken  <= s0Taken;
        end
    end

endmodule

// ==== design/retireSelect.sv ====
`timescale 1ns/1ps

module retireSelect (
    input  logic                clk,
    input  logic                rst,
    input  logic                winStrobe,
    input  logic                s0Valid,
    input  logic                s0Busy,
    input  commitPkg::addrT     s0Pc,
    input  logic                s0DstWe,
    input  commitPkg::archRegT  s0DstL,
    input  commitPkg::physRegT  s0DstP,
    input  commitPkg::physRegT  s0DstStale,
    input  logic                s0Exc,
    input  commitPkg::excCodeT  s0ExcCode,
    input  logic                s1Valid,
    input  logic                s1Busy,
    input  logic                s1Bubble,
    input  logic                s1DstWe,
    input  commitPkg::archRegT  s1DstL,
    input  commitPkg::physRegT  s1DstP,
    input  commitPkg::physRegT  s1DstStale,
    input  logic                s1Exc,
    input  commitPkg::excCodeT  s1ExcCode,
    input  logic                flush,
    input  logic                waitingDelaySlot,
    output logic                commitValid0,
    output logic                commitWe0,
    output commitPkg::archRegT  commitArch0,
    output commitPkg::physRegT  commitPhys0,
    output commitPkg::physRegT  commitStale0,
    output logic                commitValid1,
    output logic                commitWe1,
    output commitPkg::archRegT  commitArch1,
    output commitPkg::physRegT  commitPhys1,
    output commitPkg::physRegT  commitStale1,
    output logic                excValid,
    output commitPkg::excCodeT  excCode,
    output commitPkg::addrT     excPc,
    output logic                slot0Retired
);

    logic good0;
    logic good1;
    logic retire0;
    logic retire1;
    logic exc0;
    logic exc1;

    // a strobe seen while flushing belongs to the wrong path
    assign good0 = winStrobe && s0Valid && !s0Busy && !flush;

    // during a delay-slot wait only the delay slot itself may leave the window
    assign good1 = good0 && s1Valid && !s1Busy && !s1Bubble && !waitingDelaySlot;

    assign retire0 = good0 && !s0Exc;
    assign retire1 = good1 && !s1Exc && !s0Exc; // in order, nothing passes an older exception

    assign exc0 = good0 && s0Exc;
    assign exc1 = good1 && s1Exc && !s0Exc;

    always_ff @(posedge clk) begin
        if (rst) begin
            commitValid0 <= 1'b0;
            commitValid1 <= 1'b0;
            commitWe0    <= 1'b0;
            commitWe1    <= 1'b0;
            excValid     <= 1'b0;
        end else begin
            commitValid0 <= retire0;
            commitValid1 <= retire1;
            commitWe0    <= retire0 && s0DstWe;
            commitWe1    <= retire1 && s1DstWe;
            excValid     <= exc0 || exc1;
        end
    end

    always_ff @(posedge clk) begin
        commitArch0  <= s0DstL;
        commitPhys0  <= s0DstP;
        commitStale0 <= s0DstStale;
        commitArch1  <= s1DstL;
        commitPhys1  <= s1DstP;
        commitStale1 <= s1DstStale;
        excCode      <= exc0 ? s0ExcCode : s1ExcCode;
        excPc        <= exc0 ? s0Pc : s0Pc + 32'd4; // slot 1 sits one word after slot 0
    end

    assign slot0Retired = commitValid0;

endmodule

// ==== design/redirectCtrl.sv ====
`timescale 1ns/1ps

module redirectCtrl #(
    parameter commitPkg::addrT EXC_VECTOR = 32'hBFC00380
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             mispredict,
    input  logic             needDelaySlot,
    input  logic             slot0Retired,
    input  logic             excValid,
    input  commitPkg::addrT  mispredictTarget,
    output logic             flush,
    output logic             redirectValid,
    output logic             waitingDelaySlot,
    output commitPkg::addrT  redirectPc
);

    typedef enum logic {
        IDLE,
        WAIT_DELAY_SLOT
    } stateT;

    stateT           state;
    commitPkg::addrT heldTarget;
    logic            immediateMiss;
    logic            deferredMiss;
    logic            waitDone;

    assign immediateMiss = mispredict && !needDelaySlot;
    assign deferredMiss  = mispredict && needDelaySlot;

    // the delay slot retired in the previous cycle, so the held branch may redirect now
    assign waitDone = (state == WAIT_DELAY_SLOT) && slot0Retired;

    assign flush         = excValid || immediateMiss || waitDone;
    assign redirectValid = flush;

    // covers the cycle of the registered mispredict too, so a strobe right behind it is held
    assign waitingDelaySlot = (state == WAIT_DELAY_SLOT) || deferredMiss;

    always_comb begin
        if (excValid) begin
            redirectPc = EXC_VECTOR; // exceptions win over any branch redirect
        end else if (immediateMiss) begin
            redirectPc = mispredictTarget;
        end else if (waitDone) begin
            redirectPc = heldTarget;
        end else begin
            redirectPc = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;
        end else if (deferredMiss) begin
            state <= WAIT_DELAY_SLOT;
        end
    end

    always_ff @(posedge clk) begin
        if (deferredMiss) begin
            heldTarget <= mispredictTarget;
        end
    end

endmodule

// ==== design/commitUnit.sv ====
`timescale 1ns/1ps

module commitUnit #(
    parameter commitPkg::addrT EXC_VECTOR = 32'hBFC00380
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   winStrobe,
    input  logic                   s0Valid,
    input  logic                   s0Busy,
    input  commitPkg::addrT        s0Pc,
    input  commitPkg::branchKindT  s0BrKind,
    input  logic                   s0Taken,
    input  commitPkg::addrT        s0BrAddr,
    input  logic                   s0PredTaken,
    input  commitPkg::addrT        s0PredAddr,
    input  logic                   s0DstWe,
    input  commitPkg::archRegT     s0DstL,
    input  commitPkg::physRegT     s0DstP,
    input  commitPkg::physRegT     s0DstStale,
    input  logic                   s0Exc,
    input  commitPkg::excCodeT     s0ExcCode,
    input  logic                   s1Valid,
    input  logic                   s1Busy,
    input  logic                   s1Bubble,
    input  logic                   s1DstWe,
    input  commitPkg::archRegT     s1DstL,
    input  commitPkg::physRegT     s1DstP,
    input  commitPkg::physRegT     s1DstStale,
    input  logic                   s1Exc,
    input  commitPkg::excCodeT     s1ExcCode,
    output logic                   commitValid0,
    output logic                   commitWe0,
    output commitPkg::archRegT     commitArch0,
    output commitPkg::physRegT     commitPhys0,
    output commitPkg::physRegT     commitStale0,
    output logic                   commitValid1,
    output logic                   commitWe1,
    output commitPkg::archRegT     commitArch1,
    output commitPkg::physRegT     commitPhys1,
    output commitPkg::physRegT     commitStale1,
    output logic                   bpUpdValid,
    output commitPkg::addrT        bpUpdPc,
    output commitPkg::addrT        bpUpdTarget,
    output logic                   bpUpdTaken,
    output logic                   excValid,
    output commitPkg::excCodeT     excCode,
    output commitPkg::addrT        excPc,
    output logic                   flush,
    output logic                   redirectValid,
    output commitPkg::addrT        redirectPc
);

    logic            mispredict;
    logic            needDelaySlot;
    commitPkg::addrT mispredictTarget;
    logic            slot0Retired;
    logic            waitingDelaySlot;

    branchCheck uBranch (
        .clk              (clk),
        .rst              (rst),
        .winStrobe        (winStrobe),
        .s0Valid          (s0Valid),
        .s0Busy           (s0Busy),
        .s0Exc            (s0Exc),
        .s1Bubble         (s1Bubble),
        .s0Taken          (s0Taken),
        .s0PredTaken      (s0PredTaken),
        .s0BrKind         (s0BrKind),
        .s0Pc             (s0Pc),
        .s0BrAddr         (s0BrAddr),
        .s0PredAddr       (s0PredAddr),
        .flush            (flush),
        .waitingDelaySlot (waitingDelaySlot),
        .mispredict       (mispredict),
        .needDelaySlot    (needDelaySlot),
        .mispredictTarget (mispredictTarget),
        .bpUpdValid       (bpUpdValid),
        .bpUpdTaken       (bpUpdTaken),
        .bpUpdPc          (bpUpdPc),
        .bpUpdTarget      (bpUpdTarget)
    );

    retireSelect uRetire (
        .clk              (clk),
        .rst              (rst),
        .winStrobe        (winStrobe),
        .s0Valid          (s0Valid),
        .s0Busy           (s0Busy),
        .s0Pc             (s0Pc),
        .s0DstWe          (s0DstWe),
        .s0DstL           (s0DstL),
        .s0DstP           (s0DstP),
        .s0DstStale       (s0DstStale),
        .s0Exc            (s0Exc),
        .s0ExcCode        (s0ExcCode),
        .s1Valid          (s1Valid),
        .s1Busy           (s1Busy),
        .s1Bubble         (s1Bubble),
        .s1DstWe          (s1DstWe),
        .s1DstL           (s1DstL),
        .s1DstP           (s1DstP),
        .s1DstStale       (s1DstStale),
        .s1Exc            (s1Exc),
        .s1ExcCode        (s1ExcCode),
        .flush            (flush),
        .waitingDelaySlot (waitingDelaySlot),
        .commitValid0     (commitValid0),
        .commitWe0        (commitWe0),
        .commitArch0      (commitArch0),
        .commitPhys0      (commitPhys0),
        .commitStale0     (commitStale0),
        .commitValid1     (commitValid1),
        .commitWe1        (commitWe1),
        .commitArch1      (commitArch1),
        .commitPhys1      (commitPhys1),
        .commitStale1     (commitStale1),
        .excValid         (excValid),
        .excCode          (excCode),
        .excPc            (excPc),
        .slot0Retired     (slot0Retired)
    );

    // the only block that needs the exception vector
    redirectCtrl #(
        .EXC_VECTOR (EXC_VECTOR)
    ) uRedirect (
        .clk              (clk),
        .rst              (rst),
        .mispredict       (mispredict),
        .needDelaySlot    (needDelaySlot),
        .slot0Retired     (slot0Retired),
        .excValid         (excValid),
        .mispredictTarget (mispredictTarget),
        .flush            (flush),
        .redirectValid    (redirectValid),
        .waitingDelaySlot (waitingDelaySlot),
        .redirectPc       (redirectPc)
    );

endmodule

// ==== bench/commitUnit_checker.sv ====
`timescale 1ns/1ps

module commitUnit_checker (
    input logic               clk,
    input logic               rst,
    input logic               commitValid0,
    input logic               commitWe0,
    input commitPkg::archRegT commitArch0,
    input commitPkg::physRegT commitPhys0,
    input commitPkg::physRegT commitStale0,
    input logic               commitValid1,
    input logic               commitWe1,
    input commitPkg::archRegT commitArch1,
    input commitPkg::physRegT commitPhys1,
    input commitPkg::physRegT commitStale1,
    input logic               bpUpdValid,
    input commitPkg::addrT    bpUpdPc,
    input commitPkg::addrT    bpUpdTarget,
    input logic               bpUpdTaken,
    input logic               excValid,
    input commitPkg::excCodeT excCode,
    input commitPkg::addrT    excPc,
    input logic               flush,
    input logic               redirectValid,
    input commitPkg::addrT    redirectPc
);

    // data fields only matter while their valid is high
    commit0Check: assert property (@(posedge clk) disable iff (rst)
        commitValid0 == commitTb.expCommitValid0 && (!commitValid0
        || (commitWe0 == commitTb.expCommitWe0 && commitArch0 == commitTb.expArch0
            && commitPhys0 == commitTb.expPhys0 && commitStale0 == commitTb.expStale0)))
    else $error("error at %0t: slot 0 rename commit differs from the model", $time);

    commit1Check: assert property (@(posedge clk) disable iff (rst)
        commitValid1 == commitTb.expCommitValid1 && (!commitValid1
        || (commitWe1 == commitTb.expCommitWe1 && commitArch1 == commitTb.expArch1
            && commitPhys1 == commitTb.expPhys1 && commitStale1 == commitTb.expStale1)))
    else $error("error at %0t: slot 1 rename commit differs from the model", $time);

    bpCheck: assert property (@(posedge clk) disable iff (rst)
        bpUpdValid == commitTb.expBpValid && (!bpUpdValid || (bpUpdPc == commitTb.expBpPc
            && bpUpdTarget == commitTb.expBpTarget && bpUpdTaken == commitTb.expBpTaken)))
    else $error("error at %0t: predictor update differs from the model", $time);

    excCheck: assert property (@(posedge clk) disable iff (rst)
        excValid == commitTb.expExcValid && (!excValid
        || (excCode == commitTb.expExcCode && excPc == commitTb.expExcPc)))
    else $error("error at %0t: exception report differs from the model", $time);

    redirectCheck: assert property (@(posedge clk) disable iff (rst)
        flush == commitTb.expFlush && redirectValid == commitTb.expFlush
        && (!flush || redirectPc == commitTb.expRedirectPc))
    else $error("error at %0t: flush or redirect differs from the model", $time);

    // nothing may be active in the first cycle out of reset
    quietAfterReset: assert property (@(posedge clk) $fell(rst) |->
        !(commitValid0 || commitValid1 || bpUpdValid || excValid || flush || redirectValid))
    else $error("error at %0t: an output was active right after reset", $time);

endmodule

// ==== bench/commitTb.sv ====
`timescale 1ns/1ps

module commitTb;

    localparam commitPkg::addrT EXC_VECTOR = 32'hBFC00380;
    localparam int NUM_WINDOWS = 400;
    localparam int WAIT_LIMIT  = 40;

    logic clk;
    logic rst;
    logic winStrobe;
    logic s0Valid, s0Busy, s0Taken, s0PredTaken, s0DstWe, s0Exc;
    logic s1Valid, s1Busy, s1Bubble, s1DstWe, s1Exc;
    commitPkg::branchKindT s0BrKind;
    commitPkg::addrT       s0Pc, s0BrAddr, s0PredAddr;
    commitPkg::archRegT    s0DstL, s1DstL;
    commitPkg::physRegT    s0DstP, s0DstStale, s1DstP, s1DstStale;
    commitPkg::excCodeT    s0ExcCode, s1ExcCode;

    logic commitValid0, commitWe0, commitValid1, commitWe1;
    logic bpUpdValid, bpUpdTaken, excValid, flush, redirectValid;
    commitPkg::archRegT commitArch0, commitArch1;
    commitPkg::physRegT commitPhys0, commitStale0, commitPhys1, commitStale1;
    commitPkg::addrT    bpUpdPc, bpUpdTarget, excPc, redirectPc;
    commitPkg::excCodeT excCode;

    // expected outputs for the current cycle that the bound checker also reads
    logic expCommitValid0, expCommitWe0, expCommitValid1, expCommitWe1;
    logic expBpValid, expBpTaken, expExcValid, expFlush;
    commitPkg::archRegT expArch0, expArch1;
    commitPkg::physRegT expPhys0, expStale0, expPhys1, expStale1;
    commitPkg::addrT    expBpPc, expBpTarget, expExcPc, expRedirectPc;
    commitPkg::excCodeT expExcCode;

    logic            missNow;   // mispredict with its delay slot in the window
    logic            deferNow;  // mispredict whose delay slot is still missing
    logic            waitState;
    logic            deferredWait;
    logic            waitDone;
    commitPkg::addrT missTarget;

    int numSlot1 = 0;
    int numBpUpdates = 0;
    int numImmediate = 0;
    int numDeferred = 0;
    int numExceptions = 0;
    int numDiscarded = 0;

    commitUnit #(.EXC_VECTOR(EXC_VECTOR)) u_dut (.*);

    bind commitUnit commitUnit_checker uChecker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign deferredWait  = waitState || deferNow;
    assign waitDone      = waitState && expCommitValid0; // the delay slot just retired
    assign expFlush      = expExcValid || missNow || waitDone;
    assign expRedirectPc = expExcValid ? EXC_VECTOR : missTarget;

    always @(posedge clk) begin : model
        logic good0;
        logic good1;
        logic checked;
        logic missed;
        good0   = winStrobe && s0Valid && !s0Busy && !expFlush;
        good1   = good0 && s1Valid && !s1Busy && !s1Bubble && !deferredWait;
        checked = good0 && !s0Exc && !deferredWait && s0BrKind != commitPkg::BR_NONE;
        missed  = checked && (s0Taken != s0PredTaken
                  || (s0Taken && s0PredTaken && s0BrAddr != s0PredAddr));
        if (rst) begin
            expCommitValid0 <= 1'b0;
            expCommitValid1 <= 1'b0;
            expCommitWe0    <= 1'b0;
            expCommitWe1    <= 1'b0;
            expBpValid      <= 1'b0;
            expExcValid     <= 1'b0;
            missNow         <= 1'b0;
            deferNow        <= 1'b0;
            waitState       <= 1'b0;
        end else begin
            expCommitValid0 <= good0 && !s0Exc;
            expCommitWe0    <= good0 && !s0Exc && s0DstWe;
            expCommitValid1 <= good1 && !s1Exc && !s0Exc;
            expCommitWe1    <= good1 && !s1Exc && !s0Exc && s1DstWe;
            expArch0        <= s0DstL;
            expPhys0        <= s0DstP;
            expStale0       <= s0DstStale;
            expArch1        <= s1DstL;
            expPhys1        <= s1DstP;
            expStale1       <= s1DstStale;
            expExcValid     <= (good0 && s0Exc) || (good1 && s1Exc);
            expExcCode      <= (good0 && s0Exc) ? s0ExcCode : s1ExcCode;
            expExcPc        <= (good0 && s0Exc) ? s0Pc : s0Pc + 32'd4;
            expBpValid      <= checked;
            expBpPc         <= s0Pc;
            expBpTarget     <= s0BrAddr;
            expBpTaken      <= s0Taken;
            missNow         <= missed && !s1Bubble;
            deferNow        <= missed && s1Bubble;
            waitState       <= expFlush ? 1'b0 : (waitState || deferNow);
            if (missed) begin
                missTarget <= s0Taken ? s0BrAddr : s0Pc + commitPkg::RETURN_OFFSET;
            end
            if (good1 && !s0Exc && !s1Exc) numSlot1++;
            if (checked) numBpUpdates++;
            if (missed && !s1Bubble) numImmediate++;
            if (missed && s1Bubble) numDeferred++;
            if ((good0 && s0Exc) || (good1 && s1Exc)) numExceptions++;
            if (winStrobe && expFlush) numDiscarded++; // wrong-path window
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic failValue(input string what);
        failRun($sformatf("error at %0t: %s differs from the model", $time, what));
    endtask

    task automatic compareOutputs();
        assert (commitValid0 == expCommitValid0 && (!commitValid0 || (commitWe0 == expCommitWe0
                && commitArch0 == expArch0 && commitPhys0 == expPhys0
                && commitStale0 == expStale0)))
        else failValue("slot 0 rename commit");
        assert (commitValid1 == expCommitValid1 && (!commitValid1 || (commitWe1 == expCommitWe1
                && commitArch1 == expArch1 && commitPhys1 == expPhys1
                && commitStale1 == expStale1)))
        else failValue("slot 1 rename commit");
        assert (bpUpdValid == expBpValid && (!bpUpdValid || (bpUpdPc == expBpPc
                && bpUpdTarget == expBpTarget && bpUpdTaken == expBpTaken)))
        else failValue("predictor update");
        assert (excValid == expExcValid && (!excValid || (excCode == expExcCode
                && excPc == expExcPc)))
        else failValue("exception report");
        assert (flush == expFlush && redirectValid == expFlush
                && (!flush || redirectPc == expRedirectPc))
        else failValue("flush and redirect");
    endtask

    task automatic driveWindow(input bit delaySlot);
        winStrobe   = 1'b1;
        s0Valid     = $urandom_range(0, 9) != 0;
        s0Busy      = $urandom_range(0, 6) == 0;
        s0Pc        = $urandom & 32'hffff_fffc;
        s0BrKind    = delaySlot ? commitPkg::BR_NONE
                                : commitPkg::branchKindT'($urandom_range(0, 2));
        s0Taken     = $urandom_range(0, 1) == 1;
        s0PredTaken = ($urandom_range(0, 3) == 0) ? !s0Taken : s0Taken; // mostly right
        s0BrAddr    = $urandom & 32'hffff_fffc;
        s0PredAddr  = ($urandom_range(0, 4) == 0) ? s0BrAddr + 32'd16 : s0BrAddr;
        s0DstWe     = $urandom_range(0, 3) != 0;
        s0DstL      = commitPkg::archRegT'($urandom);
        s0DstP      = commitPkg::physRegT'($urandom);
        s0DstStale  = commitPkg::physRegT'($urandom);
        s0Exc       = $urandom_range(0, 11) == 0;
        s0ExcCode   = commitPkg::excCodeT'($urandom);
        s1Valid     = $urandom_range(0, 9) != 0;
        s1Busy      = $urandom_range(0, 6) == 0;
        s1Bubble    = $urandom_range(0, 3) == 0;
        s1DstWe     = $urandom_range(0, 3) != 0;
        s1DstL      = commitPkg::archRegT'($urandom);
        s1DstP      = commitPkg::physRegT'($urandom);
        s1DstStale  = commitPkg::physRegT'($urandom);
        s1Exc       = $urandom_range(0, 11) == 0;
        s1ExcCode   = commitPkg::excCodeT'($urandom);
    endtask

    // checks what the last edge produced and then drives the next window or an idle cycle
    task automatic stepCycle(input bit strobe);
        @(negedge clk);
        compareOutputs();
        if (strobe) driveWindow(deferredWait);
        else winStrobe = 1'b0;
    endtask

    // keeps sending delay-slot windows until the held branch (or an exception) redirects
    task automatic awaitRedirect();
        int cycles;
        cycles = 0;
        while (!redirectValid) begin
            if (cycles == WAIT_LIMIT) begin
                failRun("timed out waiting for the redirect of a held mispredict");
            end else begin
                cycles++;
                stepCycle(1'b1);
            end
        end
    endtask

    task automatic drainOutputs();
        int cycles;
        cycles = 0;
        stepCycle(1'b0);
        while (commitValid0 || commitValid1 || bpUpdValid || excValid || flush) begin
            if (cycles == WAIT_LIMIT) begin
                failRun("outputs never went quiet after the last window");
            end else begin
                cycles++;
                stepCycle(1'b0);
            end
        end
    endtask

    initial begin
        int gap;
        void'($urandom(32'h20a6fe10));
        rst = 1'b1;
        driveWindow(1'b0);
        winStrobe = 1'b0;
        repeat (8) @(negedge clk);
        compareOutputs(); // outputs must already sit at their reset values
        rst = 1'b0;
        for (int i = 0; i < NUM_WINDOWS; i++) begin
            gap = $urandom_range(0, 2); // zero gap lands strobes in flush cycles
            repeat (gap) stepCycle(1'b0);
            if (deferredWait) awaitRedirect();
            stepCycle(1'b1);
        end
        stepCycle(1'b0);
        if (deferredWait) awaitRedirect();
        drainOutputs();
        if (numSlot1 > 0 && numBpUpdates > 0 && numImmediate > 0 && numDeferred > 0
                && numExceptions > 0 && numDiscarded > 0) begin
            $display("No errors");
            $finish;
        end else begin
            failRun("the random windows missed at least one commit behavior");
        end
    end

endmodule

// ==== all.f ====
design/commitPkg.sv
design/branchCheck.sv
design/retireSelect.sv
design/redirectCtrl.sv
design/commitUnit.sv
bench/commitUnit_checker.sv
bench/commitTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the commit stage testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module commitTb -f all.f -o commitSim \
    && ./obj_dir/commitSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
